/* hdl/axi_sram_defs.svh */
// width macros for the axi burst sram
// data, byte address, word index and strobe widths
`ifndef AXI_SRAM_DEFS_SVH
`define AXI_SRAM_DEFS_SVH

// full beat width, only 64-bit beats are served
`define AXI_SRAM_DATA_W 64

// byte address width on the aw and ar channels
`define AXI_SRAM_ADDR_W 32

// 1024 words in the array
`define AXI_SRAM_INDEX_BITS 10

// one strobe bit per byte lane
`define AXI_SRAM_STRB_W 8

`endif

/* hdl/axi_burst_pkg.sv */
// axi burst protocol types: burst kind, response code, beat length and size
// plus the legality check shared by both engines
package axi_burst_pkg;

   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } burst_t;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } resp_t;

   // beats minus one
   typedef logic [7:0] beat_len_t;
   // log2 of bytes per beat
   typedef logic [2:0] beat_size_t;

   // 8 bytes per beat
   localparam beat_size_t FULL_SIZE = 3'd3;

   // narrow size or odd wrap length gets slverr
   function automatic logic burst_error(beat_len_t len, beat_size_t size, burst_t burst);
      logic bad_wrap;
      bad_wrap = (burst == WRAP) && !(len inside {8'd1, 8'd3, 8'd7, 8'd15});
      return (size != FULL_SIZE) || bad_wrap;
   endfunction

endpackage

/* hdl/sram_map_pkg.sv */
// memory map types: address union, word index, data and strobe words
// and the per-beat index step
`include "axi_sram_defs.svh"

package sram_map_pkg;

   localparam int OFF_W = $clog2(`AXI_SRAM_STRB_W);
   localparam int TAG_W = `AXI_SRAM_ADDR_W - `AXI_SRAM_INDEX_BITS - OFF_W;

   typedef logic [`AXI_SRAM_INDEX_BITS-1:0] word_idx_t;
   typedef logic [`AXI_SRAM_DATA_W-1:0]     data_t;
   typedef logic [`AXI_SRAM_STRB_W-1:0]     strb_t;

   // tag bits above the array are ignored, so addresses wrap
   typedef struct packed {
      logic [TAG_W-1:0] tag;
      word_idx_t        idx;
      logic [OFF_W-1:0] off;
   } sram_addr_map_t;

   typedef union packed {
      logic [`AXI_SRAM_ADDR_W-1:0] raw;
      sram_addr_map_t              map;
   } sram_addr_t;

   // fixed holds, incr steps, wrap steps inside the aligned block
   function automatic word_idx_t next_index(word_idx_t idx, word_idx_t mask,
                                            axi_burst_pkg::burst_t burst);
      word_idx_t inc;
      inc = word_idx_t'(idx + 1'b1);
      case (burst)
         axi_burst_pkg::FIXED: return idx;
         axi_burst_pkg::WRAP:  return (idx & ~mask) | (inc & mask);
         default:              return inc;
      endcase
   endfunction

endpackage

/* hdl/sram_array.sv */
// byte-lane word array
// strobed write port, registered read port with enable
`timescale 1ns/1ps
`include "axi_sram_defs.svh"

module sram_array (
   input  logic                   clk,
   input  logic                   wr_en,
   input  sram_map_pkg::word_idx_t wr_idx,
   input  sram_map_pkg::strb_t     wr_strb,
   input  sram_map_pkg::data_t     wr_data,
   input  logic                   rd_en,
   input  sram_map_pkg::word_idx_t rd_idx,
   output sram_map_pkg::data_t     rd_word
);

   localparam int DEPTH = 1 << `AXI_SRAM_INDEX_BITS;

   // eight byte lanes per word
   logic [`AXI_SRAM_STRB_W-1:0][7:0] mem [DEPTH];

   // only lanes with a strobe bit change
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < `AXI_SRAM_STRB_W; b++) begin
            if (wr_strb[b]) begin
               mem[wr_idx][b] <= wr_data[b*8 +: 8];
            end
         end
      end
   end

   // one cycle read latency
   // word holds while rd_en is low, so stalled beats keep their data
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_word <= mem[rd_idx];
      end
   end

endmodule

/* hdl/axi_write_engine.sv */
// write side: aw capture, beat addressing, strobed array writes
// and the b channel
`timescale 1ns/1ps

module axi_write_engine (
   input  logic                       clk,
   input  logic                       rst,
   input  sram_map_pkg::sram_addr_t   awaddr,
   input  axi_burst_pkg::beat_len_t   awlen,
   input  axi_burst_pkg::beat_size_t  awsize,
   input  axi_burst_pkg::burst_t      awburst,
   input  logic                       awvalid,
   output logic                       awready,
   input  logic                       wlast,
   input  logic                       wvalid,
   output logic                       wready,
   output axi_burst_pkg::resp_t       bresp,
   output logic                       bvalid,
   input  logic                       bready,
   output logic                       wr_en,
   output sram_map_pkg::word_idx_t    wr_idx
);

   typedef enum logic [1:0] {
      W_IDLE = 2'b00,
      W_DATA = 2'b01,
      W_RESP = 2'b11
   } wr_state_t;

   wr_state_t                 state;
   sram_map_pkg::word_idx_t   idx;
   sram_map_pkg::word_idx_t   mask;
   axi_burst_pkg::burst_t     burst;
   axi_burst_pkg::beat_len_t  len;
   axi_burst_pkg::beat_len_t  count;
   logic                      cfg_err;
   logic                      resp_err;
   logic                      aw_hs;
   logic                      w_hs;
   logic                      last_beat;

   assign aw_hs     = awvalid && awready;
   assign w_hs      = wvalid && wready;
   assign last_beat = (count == len);

   assign awready = (state == W_IDLE);
   assign wready  = (state == W_DATA);
   assign bvalid  = (state == W_RESP);
   assign bresp   = resp_err ? axi_burst_pkg::SLVERR : axi_burst_pkg::OKAY;

   // bad bursts still take their beats but never touch the array
   assign wr_en  = w_hs && !cfg_err;
   assign wr_idx = idx;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= W_IDLE;
      end else begin
         case (state)
            W_IDLE: if (aw_hs) state <= W_DATA;
            W_DATA: if (w_hs && last_beat) state <= W_RESP;
            W_RESP: if (bready) state <= W_IDLE;
            default: state <= W_IDLE;
         endcase
      end
   end

   // burst context, loaded on aw and stepped per beat
   always_ff @(posedge clk) begin
      if (aw_hs) begin
         idx      <= awaddr.map.idx;
         mask     <= sram_map_pkg::word_idx_t'(awlen);
         burst    <= awburst;
         len      <= awlen;
         count    <= '0;
         cfg_err  <= axi_burst_pkg::burst_error(awlen, awsize, awburst);
         resp_err <= axi_burst_pkg::burst_error(awlen, awsize, awburst);
      end else if (w_hs) begin
         idx   <= sram_map_pkg::next_index(idx, mask, burst);
         count <= count + 8'd1;
         // master's wlast must sit on beat len
         if (wlast != last_beat) begin
            resp_err <= 1'b1;
         end
      end
   end

endmodule

/* hdl/axi_read_engine.sv */
// read side: ar capture, beat addressing, array read enable
// and the r channel with back-pressure
`timescale 1ns/1ps

module axi_read_engine (
   input  logic                       clk,
   input  logic                       rst,
   input  sram_map_pkg::sram_addr_t   araddr,
   input  axi_burst_pkg::beat_len_t   arlen,
   input  axi_burst_pkg::beat_size_t  arsize,
   input  axi_burst_pkg::burst_t      arburst,
   input  logic                       arvalid,
   output logic                       arready,
   output sram_map_pkg::data_t        rdata,
   output axi_burst_pkg::resp_t       rresp,
   output logic                       rlast,
   output logic                       rvalid,
   input  logic                       rready,
   input  sram_map_pkg::data_t        rd_word,
   output logic                       rd_en,
   output sram_map_pkg::word_idx_t    rd_idx
);

   typedef enum logic {
      R_IDLE = 1'b0,
      R_DATA = 1'b1
   } rd_state_t;

   rd_state_t                 state;
   sram_map_pkg::word_idx_t   idx;
   sram_map_pkg::word_idx_t   mask;
   sram_map_pkg::word_idx_t   step_idx;
   axi_burst_pkg::burst_t     burst;
   axi_burst_pkg::beat_len_t  len;
   axi_burst_pkg::beat_len_t  count;
   logic                      err;
   logic                      ar_hs;
   logic                      r_hs;
   logic                      last_beat;

   assign ar_hs     = arvalid && arready;
   assign r_hs      = rvalid && rready;
   assign last_beat = (count == len);

   assign arready = (state == R_IDLE);
   assign rvalid  = (state == R_DATA);
   assign rlast   = rvalid && last_beat;

   // error bursts return zeros, the array output is ignored
   assign rdata = err ? '0 : rd_word;
   assign rresp = err ? axi_burst_pkg::SLVERR : axi_burst_pkg::OKAY;

   assign step_idx = sram_map_pkg::next_index(idx, mask, burst);

   // first index on ar, next index on each accepted beat but the last
   // no read while stalled, so rdata holds under back-pressure
   assign rd_en  = ar_hs || (r_hs && !last_beat);
   assign rd_idx = ar_hs ? araddr.map.idx : step_idx;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= R_IDLE;
      end else begin
         case (state)
            R_IDLE: if (ar_hs) state <= R_DATA;
            R_DATA: if (r_hs && last_beat) state <= R_IDLE;
            default: state <= R_IDLE;
         endcase
      end
   end

   // idx tracks the beat currently on the r channel
   always_ff @(posedge clk) begin
      if (ar_hs) begin
         idx   <= araddr.map.idx;
         mask  <= sram_map_pkg::word_idx_t'(arlen);
         burst <= arburst;
         len   <= arlen;
         count <= '0;
         err   <= axi_burst_pkg::burst_error(arlen, arsize, arburst);
      end else if (r_hs) begin
         idx   <= step_idx;
         count <= count + 8'd1;
      end
   end

endmodule

/* hdl/axi_sram.sv */
// axi burst sram top
// write engine and read engine around a shared byte-lane array
`timescale 1ns/1ps

module axi_sram (
   input  logic                       clk,
   input  logic                       rst,

   // read address
   input  sram_map_pkg::sram_addr_t   araddr,
   input  axi_burst_pkg::beat_len_t   arlen,
   input  axi_burst_pkg::beat_size_t  arsize,
   input  axi_burst_pkg::burst_t      arburst,
   input  logic                       arvalid,
   output logic                       arready,

   // read data
   output sram_map_pkg::data_t        rdata,
   output axi_burst_pkg::resp_t       rresp,
   output logic                       rlast,
   output logic                       rvalid,
   input  logic                       rready,

   // write address
   input  sram_map_pkg::sram_addr_t   awaddr,
   input  axi_burst_pkg::beat_len_t   awlen,
   input  axi_burst_pkg::beat_size_t  awsize,
   input  axi_burst_pkg::burst_t      awburst,
   input  logic                       awvalid,
   output logic                       awready,

   // write data
   input  sram_map_pkg::data_t        wdata,
   input  sram_map_pkg::strb_t        wstrb,
   input  logic                       wlast,
   input  logic                       wvalid,
   output logic                       wready,

   // write response
   output axi_burst_pkg::resp_t       bresp,
   output logic                       bvalid,
   input  logic                       bready
);

   logic                    wr_en;
   sram_map_pkg::word_idx_t wr_idx;
   logic                    rd_en;
   sram_map_pkg::word_idx_t rd_idx;
   sram_map_pkg::data_t     rd_word;

   // w payload goes straight to the array, engine only steers the index
   axi_write_engine u_write (
      .clk, .rst,
      .awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
      .wlast, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .wr_en, .wr_idx
   );

   sram_array u_array (
      .clk,
      .wr_en, .wr_idx, .wr_strb(wstrb), .wr_data(wdata),
      .rd_en, .rd_idx, .rd_word
   );

   axi_read_engine u_read (
      .clk, .rst,
      .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
      .rdata, .rresp, .rlast, .rvalid, .rready,
      .rd_word, .rd_en, .rd_idx
   );

endmodule

/* test/axi_sram_assertions.sv */
// concurrent checks on the r, b, w and ar handshakes
// bound into the axi sram top
`timescale 1ns/1ps

module axi_sram_assertions (
   input logic                 clk,
   input logic                 rst,
   input sram_map_pkg::data_t  rdata,
   input axi_burst_pkg::resp_t rresp,
   input logic                 rlast,
   input logic                 rvalid,
   input logic                 rready,
   input logic                 bvalid,
   input logic                 bready,
   input logic                 wlast,
   input logic                 wvalid,
   input logic                 wready,
   input logic                 arready
);

   // failed checks so far
   int fail_count = 0;

   // stalled r beat keeps valid and payload
   assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp) && $stable(rlast))
      else begin
         $error("r beat changed while stalled");
         fail_count++;
      end

   // response waits for bready
   assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
      else begin
         $error("bvalid dropped without bready");
         fail_count++;
      end

   // wready ends exactly after the wlast beat
   assert property (@(posedge clk) disable iff (rst)
      wvalid && wready |=> (wready == !$past(wlast)))
      else begin
         $error("wready does not follow wlast");
         fail_count++;
      end

   // one read burst at a time, ar stays closed until the last beat is taken
   assert property (@(posedge clk) disable iff (rst)
      rvalid && !(rready && rlast) |=> !arready)
      else begin
         $error("arready reopened before the last r beat");
         fail_count++;
      end

endmodule

bind axi_sram axi_sram_assertions u_assertions (.*);

/* test/axi_sram_tb.sv */
// testbench for the axi burst sram
// transaction table, byte reference model, channel drivers, compare tasks
`timescale 1ns/1ps
`include "axi_sram_defs.svh"

module axi_sram_tb;

   localparam int LIMIT = 200;
   localparam int WORDS = 1 << `AXI_SRAM_INDEX_BITS;

   typedef struct {
      bit                        is_write;
      logic [31:0]               addr;
      axi_burst_pkg::beat_len_t  len;
      axi_burst_pkg::burst_t     burst;
      axi_burst_pkg::beat_size_t size;
      sram_map_pkg::strb_t       strb;
      axi_burst_pkg::resp_t      resp;
   } txn_t;

   logic clk, rst;
   sram_map_pkg::sram_addr_t araddr, awaddr;
   axi_burst_pkg::beat_len_t arlen, awlen;
   axi_burst_pkg::beat_size_t arsize, awsize;
   axi_burst_pkg::burst_t arburst, awburst;
   logic arvalid, arready, rlast, rvalid, rready, awvalid, awready;
   logic wlast, wvalid, wready, bvalid, bready;
   sram_map_pkg::data_t rdata, wdata;
   sram_map_pkg::strb_t wstrb;
   axi_burst_pkg::resp_t rresp, bresp;

   integer seed = 32'h32df8a81;
   txn_t table_q[$];
   // expected memory, one byte per entry
   logic [7:0] ref_mem [WORDS*8];

   axi_sram DUT (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_fail(string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_data(sram_map_pkg::data_t got, sram_map_pkg::data_t exp, string what);
      if (got !== exp)
         stop_fail($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp));
   endtask

   task automatic check_resp(axi_burst_pkg::resp_t got, axi_burst_pkg::resp_t exp, string what);
      if (got !== exp)
         stop_fail($sformatf("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
   endtask

   task automatic check_flag(logic got, logic exp, string what);
      if (got !== exp)
         stop_fail($sformatf("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp));
   endtask

   // protocol checker errors stop the run too
   always @(negedge clk) begin
      if (DUT.u_assertions.fail_count != 0)
         stop_fail("a protocol assertion in the bound checker failed");
   end

   // one cycle of a bounded wait
   task automatic next_cycle(inout int n, input string what);
      @(negedge clk);
      n++;
      if (n > LIMIT)
         stop_fail($sformatf("timeout at %0t ns while waiting for %s", $time, what));
   endtask

   // ready is high three times out of four
   function automatic logic pick_ready();
      return ($random(seed) & 3) != 0;
   endfunction

   // wrap stays inside the aligned block of len+1 words
   function automatic int advance_word(int idx, txn_t t);
      int span;
      span = t.len + 1;
      case (t.burst)
         axi_burst_pkg::FIXED: return idx;
         axi_burst_pkg::WRAP:  return (idx / span) * span + ((idx % span) + 1) % span;
         default:              return (idx + 1) % WORDS;
      endcase
   endfunction

   function automatic sram_map_pkg::data_t ref_word(int idx);
      sram_map_pkg::data_t w;
      for (int b = 0; b < 8; b++)
         w[b*8 +: 8] = ref_mem[idx*8 + b];
      return w;
   endfunction

   task automatic run_write(txn_t t);
      int idx, n;
      sram_map_pkg::data_t d;
      awaddr.raw = t.addr;
      awlen = t.len;
      awsize = t.size;
      awburst = t.burst;
      awvalid = 1'b1;
      n = 0;
      while (!awready) next_cycle(n, "awready");
      @(negedge clk);
      awvalid = 1'b0;
      idx = (t.addr / 8) % WORDS;
      for (int i = 0; i <= t.len; i++) begin
         d = {$random(seed), $random(seed)};
         wdata = d;
         wstrb = t.strb;
         wlast = (i == t.len);
         wvalid = 1'b1;
         n = 0;
         while (!wready) next_cycle(n, "wready");
         @(negedge clk);
         // error bursts must leave memory alone
         if (t.resp == axi_burst_pkg::OKAY) begin
            for (int b = 0; b < 8; b++)
               if (t.strb[b]) ref_mem[idx*8 + b] = d[b*8 +: 8];
         end
         idx = advance_word(idx, t);
      end
      wvalid = 1'b0;
      wlast = 1'b0;
      n = 0;
      bready = pick_ready();
      while (!(bvalid && bready)) begin
         next_cycle(n, "bvalid with bready");
         bready = pick_ready();
      end
      check_resp(bresp, t.resp, "bresp");
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic run_read(txn_t t);
      int idx, n;
      sram_map_pkg::data_t exp;
      araddr.raw = t.addr;
      arlen = t.len;
      arsize = t.size;
      arburst = t.burst;
      arvalid = 1'b1;
      n = 0;
      while (!arready) next_cycle(n, "arready");
      check_flag(rvalid, 1'b0, "rvalid before ar handshake");
      @(negedge clk);
      arvalid = 1'b0;
      // first beat exactly one cycle after the ar handshake
      check_flag(rvalid, 1'b1, "rvalid one cycle after ar handshake");
      idx = (t.addr / 8) % WORDS;
      for (int i = 0; i <= t.len; i++) begin
         n = 0;
         rready = pick_ready();
         while (!(rvalid && rready)) begin
            next_cycle(n, "rvalid with rready");
            rready = pick_ready();
         end
         exp = (t.resp == axi_burst_pkg::OKAY) ? ref_word(idx) : '0;
         check_data(rdata, exp, "rdata");
         check_resp(rresp, t.resp, "rresp");
         check_flag(rlast, i == t.len, "rlast");
         @(negedge clk);
         idx = advance_word(idx, t);
      end
      rready = 1'b0;
   endtask

   task automatic add_entry(bit wr, logic [31:0] addr, int len, axi_burst_pkg::burst_t burst,
                            int size, sram_map_pkg::strb_t strb, axi_burst_pkg::resp_t resp);
      txn_t t;
      t = '{wr, addr, len, burst, size, strb, resp};
      table_q.push_back(t);
   endtask

   // kind, address, len, burst, size, strobes, expected response
   task automatic load_table();
      add_entry(1, 32'h0000, 3, axi_burst_pkg::INCR, 3, 8'hff, axi_burst_pkg::OKAY);
      add_entry(0, 32'h0000, 3, axi_burst_pkg::INCR, 3, 8'hff, axi_burst_pkg::OKAY);
      add_entry(1, 32'h0100, 15, axi_burst_pkg::INCR, 3, 8'hff, axi_burst_pkg::OKAY);
      add_entry(0, 32'h0100, 15, axi_burst_pkg::INCR, 3, 8'hff, axi_burst_pkg::OKAY);
      // partial strobes on words already written
      add_entry(1, 32'h0000, 1, axi_burst_pkg::INCR, 3, 8'ha5, axi_burst_pkg::OKAY);
      add_entry(1, 32'h0008, 2, axi_burst_pkg::FIXED, 3, 8'h0f, axi_burst_pkg::OKAY);
      add_entry(1, 32'h0018, 3, axi_burst_pkg::FIXED, 3, 8'hff, axi_burst_pkg::OKAY);
      add_entry(0, 32'h0000, 3, axi_burst_pkg::INCR, 3, 8'hff, axi_burst_pkg::OKAY);
      add_entry(0, 32'h0018, 2, axi_burst_pkg::FIXED, 3, 8'hff, axi_burst_pkg::OKAY);
      // wrap reads starting mid-block
      add_entry(0, 32'h0128, 7, axi_burst_pkg::WRAP, 3, 8'hff, axi_burst_pkg::OKAY);
      add_entry(0, 32'h0108, 3, axi_burst_pkg::WRAP, 3, 8'hff, axi_burst_pkg::OKAY);
      // narrow size and bad wrap length
      add_entry(1, 32'h0100, 3, axi_burst_pkg::INCR, 2, 8'hff, axi_burst_pkg::SLVERR);
      add_entry(1, 32'h0100, 2, axi_burst_pkg::WRAP, 3, 8'hff, axi_burst_pkg::SLVERR);
      add_entry(0, 32'h0100, 4, axi_burst_pkg::WRAP, 3, 8'hff, axi_burst_pkg::SLVERR);
      add_entry(0, 32'h0100, 1, axi_burst_pkg::INCR, 1, 8'hff, axi_burst_pkg::SLVERR);
      add_entry(0, 32'h0100, 15, axi_burst_pkg::INCR, 3, 8'hff, axi_burst_pkg::OKAY);
      add_entry(1, 32'h01f8, 15, axi_burst_pkg::WRAP, 3, 8'hff, axi_burst_pkg::OKAY);
      add_entry(0, 32'h0180, 15, axi_burst_pkg::INCR, 3, 8'hff, axi_burst_pkg::OKAY);
      // last word rolls over to word 0, tag bits ignored
      add_entry(1, 32'h1ff8, 1, axi_burst_pkg::INCR, 3, 8'hff, axi_burst_pkg::OKAY);
      add_entry(0, 32'h3ff8, 1, axi_burst_pkg::INCR, 3, 8'hff, axi_burst_pkg::OKAY);
      add_entry(0, 32'h2000, 3, axi_burst_pkg::INCR, 3, 8'hff, axi_burst_pkg::OKAY);
   endtask

   initial begin
      rst = 1'b1;
      araddr = '0;
      awaddr = '0;
      arlen = '0;
      awlen = '0;
      arsize = 3'd3;
      awsize = 3'd3;
      arburst = axi_burst_pkg::INCR;
      awburst = axi_burst_pkg::INCR;
      arvalid = 1'b0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wlast = 1'b0;
      wvalid = 1'b0;
      rready = 1'b0;
      bready = 1'b0;
      load_table();
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // idle channel state out of reset
      check_flag(arready, 1'b1, "arready after reset");
      check_flag(awready, 1'b1, "awready after reset");
      check_flag(rvalid, 1'b0, "rvalid after reset");
      check_flag(wready, 1'b0, "wready after reset");
      check_flag(bvalid, 1'b0, "bvalid after reset");
      foreach (table_q[i]) begin
         if (table_q[i].is_write)
            run_write(table_q[i]);
         else
            run_read(table_q[i]);
      end
      if (DUT.u_assertions.fail_count == 0) begin
         $display("*** PASSED ***");
         $finish;
      end else begin
         stop_fail("a protocol assertion in the bound checker failed");
      end
   end

endmodule

/* files.f */
+incdir+hdl
hdl/axi_burst_pkg.sv
hdl/sram_map_pkg.sv
hdl/sram_array.sv
hdl/axi_write_engine.sv
hdl/axi_read_engine.sv
hdl/axi_sram.sv
test/axi_sram_assertions.sv
test/axi_sram_tb.sv
